//--- flist.f
+incdir+.
i3c_pkg.sv
i3c_table_if.sv
i3c_table_ram.sv
i3c_csr_frontend.sv
i3c_bus_engine.sv
i3c_core.sv
i3c_wrapper.sv
i3c_checker.sv
i3c_tb_monitor.sv
i3c_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= i3c_tb
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- i3c_tb.sv
// Target model acknowledges dynamic addresses below 0x40 only; bus lines have no open drain model
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_tb;

  localparam int KBus = 0;
  localparam int KRead = 1;
  localparam int KWrite = 2;
  localparam int KCmd = 3;
  localparam int KIdle = 4;

  logic        clk = 1'b0;
  logic        arst_n = 1'b0;
  logic        csr_req = 1'b0;
  logic        csr_we = 1'b0;
  logic [7:0]  csr_addr = '0;
  logic [15:0] csr_wdata = '0;
  logic        csr_ack;
  logic [15:0] csr_rdata;
  logic        sda_in;
  logic        scl;
  logic        sda_out;
  logic        odpp;
  logic        pull = 1'b0;
  logic        scl_d = 1'b1;
  logic        sda_d = 1'b1;
  int          bitn = -1;
  logic [6:0]  tgt_addr = '0;
  logic [15:0] lfsr = 16'd23776;
  logic        table_ready = 1'b0;

  // Stimulus table
  string       st_name[$];
  int          st_kind[$];
  logic [7:0]  st_addr[$];
  logic [15:0] st_data[$];
  logic [15:0] st_exp[$];
  logic [7:0]  dat_model[`I3C_TABLE_DEPTH];

  i3c_wrapper i_i3c_wrapper (
    .clk_i(clk), .arst_n_i(arst_n), .csr_req_i(csr_req), .csr_we_i(csr_we),
    .csr_addr_i(csr_addr), .csr_wdata_i(csr_wdata), .csr_ack_o(csr_ack),
    .csr_rdata_o(csr_rdata), .sda_i(sda_in), .scl_o(scl), .sda_o(sda_out),
    .sel_od_pp_o(odpp)
  );

  i3c_tb_monitor i_monitor (
    .clk_i(clk), .arst_n_i(arst_n), .scl_i(scl), .sda_line_i(sda_in),
    .sda_drv_i(sda_out), .odpp_i(odpp)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  function automatic logic acks(input logic [6:0] addr);
    return addr < 7'h40;
  endfunction

  // Target pulls SDA low through the ACK slot, bit 8 of the frame
  assign sda_in = pull ? 1'b0 : sda_out;
  always @(posedge clk) begin
    scl_d <= scl;
    sda_d <= sda_out;
    if (scl_d && scl && sda_d && !sda_out) begin
      bitn <= -1;
    end else if (scl_d && !scl) begin
      bitn <= bitn + 1;
      pull <= (bitn + 1 == 8) && acks(tgt_addr);
    end else if (!scl_d && scl && bitn >= 0 && bitn < 7) begin
      tgt_addr <= {tgt_addr[5:0], sda_out};
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic add_step(input string n, input int k, input logic [7:0] a,
                          input logic [15:0] d, input logic [15:0] e);
    st_name.push_back(n);
    st_kind.push_back(k);
    st_addr.push_back(a);
    st_data.push_back(d);
    st_exp.push_back(e);
  endtask

  task automatic build_table();
    add_step("bus_idle", KBus, 0, 0, 16'h0006);
    add_step("status_reset", KRead, `I3C_CSR_STATUS, 0, 0);
    for (int i = 0; i < `I3C_TABLE_DEPTH; i++) begin
      add_step($sformatf("dat%0d_reset", i), KRead, `I3C_CSR_DAT_BASE + 8'(i), 0, 0);
      add_step($sformatf("dst%0d_reset", i), KRead, `I3C_CSR_DST_BASE + 8'(i), 0, 0);
    end
    add_step("dat0_wr", KWrite, `I3C_CSR_DAT_BASE, 16'h0092, 0);
    add_step("dat1_wr", KWrite, `I3C_CSR_DAT_BASE + 1, 16'h00d5, 0);
    add_step("dat2_wr", KWrite, `I3C_CSR_DAT_BASE + 2, 16'h0033, 0);
    add_step("dat3_wr", KWrite, `I3C_CSR_DAT_BASE + 3, 16'h00a1, 0);
    add_step("dat0_rd", KRead, `I3C_CSR_DAT_BASE, 0, 16'h0092);
    add_step("dat1_rd", KRead, `I3C_CSR_DAT_BASE + 1, 0, 16'h00d5);
    add_step("dat2_rd", KRead, `I3C_CSR_DAT_BASE + 2, 0, 16'h0033);
    add_step("dst0_wr", KWrite, `I3C_CSR_DST_BASE, 16'h03ff, 0);
    add_step("dst0_ignored", KRead, `I3C_CSR_DST_BASE, 0, 0);
    add_step("cmd_ack", KCmd, 0, 0, 0);
    add_step("frame_ack", KIdle, 0, 0, 0);
    add_step("dst0_count1", KRead, `I3C_CSR_DST_BASE, 0, 16'h0001);
    add_step("cmd_ack_again", KCmd, 0, 0, 0);
    add_step("frame_ack_again", KIdle, 0, 0, 0);
    add_step("dst0_count2", KRead, `I3C_CSR_DST_BASE, 0, 16'h0002);
    add_step("cmd_nack", KCmd, 1, 0, 0);
    add_step("frame_nack", KIdle, 0, 0, 0);
    add_step("dst1_nack", KRead, `I3C_CSR_DST_BASE + 1, 0, 16'h0100);
    add_step("cmd_invalid", KCmd, 2, 0, 0);
    add_step("no_frame_invalid", KIdle, 0, 0, 0);
    add_step("dst2_invalid", KRead, `I3C_CSR_DST_BASE + 2, 0, 16'h0200);
    add_step("cmd_busy", KCmd, 3, 0, 0);
    add_step("status_busy", KRead, `I3C_CSR_STATUS, 0, 16'h0001);
    add_step("dat3_during_frame", KRead, `I3C_CSR_DAT_BASE + 3, 0, 16'h00a1);
    add_step("frame_busy", KIdle, 0, 0, 0);
    add_step("dst3_count1", KRead, `I3C_CSR_DST_BASE + 3, 0, 16'h0001);
  endtask

  // Four-phase access, outputs sampled on the falling edge
  task automatic csr_access(input logic we, input logic [7:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata);
    @(posedge clk);
    csr_req   <= 1'b1;
    csr_we    <= we;
    csr_addr  <= addr;
    csr_wdata <= wdata;
    @(negedge clk);
    while (!csr_ack) @(negedge clk);
    rdata = csr_rdata;
    @(posedge clk);
    csr_req <= 1'b0;
    @(negedge clk);
    while (csr_ack) @(negedge clk);
  endtask

  initial begin
    logic [15:0] rd;
    logic [7:0]  cmd_byte;
    logic [7:0]  pend_entry;
    logic [7:0]  pend_byte;
    build_table();
    foreach (dat_model[i]) dat_model[i] = '0;
    pend_entry = '0;
    pend_byte  = '0;
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    for (int s = 0; s < st_name.size(); s++) begin
      case (st_kind[s])
        KBus: i_monitor.check_bus_idle(st_name[s], st_exp[s][2:0]);
        KRead: begin
          csr_access(1'b0, st_addr[s], 16'd0, rd);
          i_monitor.check_value(st_name[s], st_exp[s], rd);
        end
        KWrite: begin
          csr_access(1'b1, st_addr[s], st_data[s], rd);
          if (st_addr[s] < 8'(`I3C_TABLE_DEPTH)) dat_model[st_addr[s][2:0]] = st_data[s][7:0];
        end
        KCmd: begin
          next_byte(cmd_byte);
          pend_entry = dat_model[st_addr[s][2:0]];
          pend_byte  = cmd_byte;
          csr_access(1'b1, `I3C_CSR_CMD, {cmd_byte, 5'd0, st_addr[s][2:0]}, rd);
        end
        default: begin
          // Poll until the engine reports idle, then compare the frame
          do csr_access(1'b0, `I3C_CSR_STATUS, 16'd0, rd); while (rd[0]);
          i_monitor.check_frame(st_name[s], pend_entry[7], pend_entry[6:0],
                                acks(pend_entry[6:0]), pend_byte);
        end
      endcase
    end
    $display("Checks passed %0d, failed %0d", i_monitor.pass_count, i_monitor.fail_count);
    if (i_monitor.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Longest frame plus status polling, per step, with a margin
  initial begin
    int unsigned limit;
    wait (table_ready);
    limit = st_name.size() * 2 * ((2 * 18 + 3) * `I3C_SCL_DIV + 20) + 200;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d clocks, the DUT stopped responding", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- i3c_tb_monitor.sv
// Decodes frames from the resolved SDA line; only private writes of 9 or 18 bits are expected
`timescale 1ns/100ps

module i3c_tb_monitor (
  input logic clk_i,
  input logic arst_n_i,
  input logic scl_i,
  input logic sda_line_i,
  input logic sda_drv_i,
  input logic odpp_i
);

  int unsigned     pass_count = 0;
  int unsigned     fail_count = 0;
  logic [18:0]     frame_q[$];
  logic [18:0]     odpp_q[$];
  int unsigned     nbits_q[$];
  logic            in_frame = 1'b0;
  logic            scl_d = 1'b1;
  logic            sda_d = 1'b1;
  logic [19:0]     sh = '0;
  logic [19:0]     od_sh = '0;
  int unsigned     cnt = 0;

  // Capture on SCL rise; the last rise before STOP is the stop setup bit
  always @(posedge clk_i) begin
    scl_d <= scl_i;
    sda_d <= sda_line_i;
    if (arst_n_i && scl_d && scl_i && sda_d && !sda_line_i) begin
      in_frame <= 1'b1;
      sh       <= '0;
      od_sh    <= '0;
      cnt      <= 0;
    end else if (in_frame && scl_d && scl_i && !sda_d && sda_line_i) begin
      frame_q.push_back(sh[19:1]);
      odpp_q.push_back(od_sh[19:1]);
      nbits_q.push_back(cnt - 1);
      in_frame <= 1'b0;
    end else if (in_frame && !scl_d && scl_i) begin
      sh    <= {sh[18:0], sda_line_i};
      od_sh <= {od_sh[18:0], odpp_i};
      cnt   <= cnt + 1;
    end
  end

  task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (exp === act) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pattern(input string name, input logic [18:0] exp,
                               input logic [18:0] act);
    if (exp === act) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bus_idle(input string name, input logic [2:0] exp);
    check_value(name, {13'd0, exp}, {13'd0, scl_i, sda_drv_i, odpp_i});
  endtask

  // Expected frame from the private write rules
  task automatic check_frame(input string name, input logic valid, input logic [6:0] addr,
                             input logic acked, input logic [7:0] data);
    logic [18:0] exp;
    logic [18:0] exp_od;
    logic        t_bit;
    int unsigned exp_bits;
    if (!valid) begin
      if (frame_q.size() != 0) begin
        fail_count++;
        $display("%s: a frame was sent for an invalid entry", name);
      end else begin
        pass_count++;
        $display("PASS %s", name);
      end
    end else if (frame_q.size() == 0) begin
      fail_count++;
      $display("%s: no frame was seen on the bus", name);
    end else begin
      // T makes the count of ones over data and T odd
      t_bit    = ($countones(data) % 2) == 0;
      exp      = acked ? {1'b0, addr, 1'b0, 1'b0, data, t_bit} : {10'd0, addr, 1'b0, 1'b1};
      // Push-pull only for the eight data bits and T
      exp_od   = acked ? 19'h001ff : 19'h00000;
      exp_bits = acked ? 18 : 9;
      check_value({name, "_bits"}, 16'(exp_bits), 16'(nbits_q.pop_front()));
      check_pattern(name, exp, frame_q.pop_front());
      check_pattern({name, "_odpp"}, exp_od, odpp_q.pop_front());
    end
  endtask

endmodule

//--- i3c_checker.sv
// Bound into i3c_wrapper; frame tracking assumes START and STOP are the only SDA edges with SCL high
`timescale 1ns/100ps

module i3c_checker (
  input logic clk_i,
  input logic arst_n_i,
  input logic csr_req_i,
  input logic csr_ack_o,
  input logic scl_o,
  input logic sda_o,
  input logic sel_od_pp_o
);

  logic in_frame_q;
  logic scl_d_q;
  logic sda_d_q;

  // Frame window from START to STOP
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_frame_q <= 1'b0;
      scl_d_q    <= 1'b1;
      sda_d_q    <= 1'b1;
    end else begin
      scl_d_q <= scl_o;
      sda_d_q <= sda_o;
      if (scl_d_q && scl_o && sda_d_q && !sda_o) begin
        in_frame_q <= 1'b1;
      end else if (scl_d_q && scl_o && !sda_d_q && sda_o) begin
        in_frame_q <= 1'b0;
      end
    end
  end

  ack_rise_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(csr_ack_o) |-> csr_req_i)
    else $error("csr_ack_o rose without csr_req_i");

  ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(csr_ack_o) |-> !csr_req_i)
    else $error("csr_ack_o fell while csr_req_i was still high");

  idle_open_drain: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!in_frame_q && scl_o && sda_o) |-> !sel_od_pp_o)
    else $error("sel_od_pp_o high on an idle bus");

endmodule

bind i3c_wrapper i3c_checker i_checker (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .csr_req_i  (csr_req_i),
  .csr_ack_o  (csr_ack_o),
  .scl_o      (scl_o),
  .sda_o      (sda_o),
  .sel_od_pp_o(sel_od_pp_o)
);

//--- i3c_wrapper.sv
// Bus lines are split into in and out ports with no pad cell; the board must resolve open drain
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_wrapper (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        csr_req_i,
  input  logic        csr_we_i,
  input  logic [7:0]  csr_addr_i,
  input  logic [15:0] csr_wdata_i,
  output logic        csr_ack_o,
  output logic [15:0] csr_rdata_o,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        sel_od_pp_o
);

  i3c_table_if #(.entry_t(i3c_pkg::dat_entry_t)) dat_if ();
  i3c_table_if #(.entry_t(i3c_pkg::dst_entry_t)) dst_if ();

  i3c_core i_i3c_core (
    .clk_i,
    .arst_n_i,
    .csr_req_i,
    .csr_we_i,
    .csr_addr_i,
    .csr_wdata_i,
    .csr_ack_o,
    .csr_rdata_o,
    .dat(dat_if.client),
    .dst(dst_if.client),
    .sda_i,
    .scl_o,
    .sda_o,
    .sel_od_pp_o
  );

  // Device address table
  i3c_table_ram #(
    .entry_t(i3c_pkg::dat_entry_t),
    .Depth  (`I3C_TABLE_DEPTH)
  ) dat_memory (
    .clk_i,
    .arst_n_i,
    .mem(dat_if.memory)
  );

  // Device status table
  i3c_table_ram #(
    .entry_t(i3c_pkg::dst_entry_t),
    .Depth  (`I3C_TABLE_DEPTH)
  ) dst_memory (
    .clk_i,
    .arst_n_i,
    .mem(dst_if.memory)
  );

endmodule

//--- i3c_core.sv
// Engine owns both tables for its whole busy window, so host table accesses stall during a frame
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_core (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        csr_req_i,
  input  logic        csr_we_i,
  input  logic [7:0]  csr_addr_i,
  input  logic [15:0] csr_wdata_i,
  output logic        csr_ack_o,
  output logic [15:0] csr_rdata_o,
  i3c_table_if.client dat,
  i3c_table_if.client dst,
  input  logic        sda_i,
  output logic        scl_o,
  output logic        sda_o,
  output logic        sel_od_pp_o
);

  logic                  eng_busy;
  logic                  eng_start;
  logic [`I3C_IDX_W-1:0] eng_idx;
  logic [7:0]            eng_data;

  i3c_table_if #(.entry_t(i3c_pkg::dat_entry_t)) fe_dat ();
  i3c_table_if #(.entry_t(i3c_pkg::dst_entry_t)) fe_dst ();
  i3c_table_if #(.entry_t(i3c_pkg::dat_entry_t)) eng_dat ();
  i3c_table_if #(.entry_t(i3c_pkg::dst_entry_t)) eng_dst ();

  i3c_csr_frontend i_csr_frontend (
    .clk_i,
    .arst_n_i,
    .csr_req_i,
    .csr_we_i,
    .csr_addr_i,
    .csr_wdata_i,
    .csr_ack_o,
    .csr_rdata_o,
    .eng_busy_i (eng_busy),
    .eng_start_o(eng_start),
    .eng_idx_o  (eng_idx),
    .eng_data_o (eng_data),
    .dat        (fe_dat.client),
    .dst        (fe_dst.client)
  );

  i3c_bus_engine i_bus_engine (
    .clk_i,
    .arst_n_i,
    .start_i(eng_start),
    .idx_i  (eng_idx),
    .data_i (eng_data),
    .busy_o (eng_busy),
    .dat    (eng_dat.client),
    .dst    (eng_dst.client),
    .sda_i,
    .scl_o,
    .sda_o,
    .sel_od_pp_o
  );

  // Table ownership follows engine busy
  assign dat.req   = eng_busy ? eng_dat.req   : fe_dat.req;
  assign dat.write = eng_busy ? eng_dat.write : fe_dat.write;
  assign dat.addr  = eng_busy ? eng_dat.addr  : fe_dat.addr;
  assign dat.wdata = eng_busy ? eng_dat.wdata : fe_dat.wdata;

  assign dst.req   = eng_busy ? eng_dst.req   : fe_dst.req;
  assign dst.write = eng_busy ? eng_dst.write : fe_dst.write;
  assign dst.addr  = eng_busy ? eng_dst.addr  : fe_dst.addr;
  assign dst.wdata = eng_busy ? eng_dst.wdata : fe_dst.wdata;

  // Read data goes back to both requesters
  assign fe_dat.rdata  = dat.rdata;
  assign eng_dat.rdata = dat.rdata;
  assign fe_dst.rdata  = dst.rdata;
  assign eng_dst.rdata = dst.rdata;

endmodule

//--- i3c_bus_engine.sv
// Private write only with no clock stretching or arbitration; the target is assumed to ACK in time
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_bus_engine (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  start_i,
  input  logic [`I3C_IDX_W-1:0] idx_i,
  input  logic [7:0]            data_i,
  output logic                  busy_o,
  i3c_table_if.client           dat,
  i3c_table_if.client           dst,
  input  logic                  sda_i,
  output logic                  scl_o,
  output logic                  sda_o,
  output logic                  sel_od_pp_o
);

  localparam int unsigned Div       = `I3C_SCL_DIV;
  localparam int unsigned DivW      = $clog2(Div);
  localparam int unsigned FrameBits = 18;

  localparam logic [DivW-1:0] DivMid  = DivW'(Div / 2 - 1);
  localparam logic [DivW-1:0] DivLast = DivW'(Div - 1);

  // Send order: 0..6 address, 7 RnW, 8 ACK, 9..16 data, 17 T
  localparam logic [4:0] AckBit  = 5'd8;
  localparam logic [4:0] DataBit = 5'd9;
  localparam logic [4:0] LastBit = 5'd17;

  typedef enum logic [3:0] {
    EIdle, EDatRd, EDatChk, EStart, EBitLo, EBitHi, EStopLo, EStopHi, EDstRd, EDstWr
  } eng_state_e;

  eng_state_e            state_q;
  logic [`I3C_IDX_W-1:0] idx_q;
  logic [7:0]            data_q;
  logic [FrameBits-1:0]  shift_q;
  logic [4:0]            bit_q;
  logic [DivW-1:0]       div_q;
  logic                  acked_q;
  logic                  invalid_q;
  logic                  scl_q;
  logic                  sda_q;
  logic                  odpp_q;
  logic                  half_done;
  i3c_pkg::dst_entry_t   dst_next;

  assign half_done = div_q == DivLast;
  assign busy_o    = state_q != EIdle;

  assign scl_o       = scl_q;
  assign sda_o       = sda_q;
  assign sel_od_pp_o = odpp_q;

  assign dat.req   = state_q == EDatRd;
  assign dat.write = 1'b0;
  assign dat.addr  = idx_q;
  assign dat.wdata = '0;

  assign dst.req   = (state_q == EDstRd) || (state_q == EDstWr);
  assign dst.write = state_q == EDstWr;
  assign dst.addr  = idx_q;
  assign dst.wdata = dst_next;

  // Status update from the entry read in EDstRd
  always_comb begin
    dst_next = dst.rdata;
    if (invalid_q) begin
      dst_next.invalid = 1'b1;
      dst_next.nack    = 1'b0;
    end else if (acked_q) begin
      dst_next.count   = dst.rdata.count + 8'd1;
      dst_next.nack    = 1'b0;
      dst_next.invalid = 1'b0;
    end else begin
      dst_next.nack    = 1'b1;
      dst_next.invalid = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == EIdle && start_i) begin
      idx_q  <= idx_i;
      data_q <= data_i;
    end
    if (state_q == EDatChk) begin
      // ACK slot sent as 1 so the line is released
      shift_q <= {dat.rdata.addr, 1'b0, 1'b1, data_q, ~^data_q};
    end else if (state_q == EBitHi && half_done) begin
      shift_q <= shift_q << 1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= EIdle;
      bit_q     <= '0;
      div_q     <= '0;
      acked_q   <= 1'b0;
      invalid_q <= 1'b0;
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      odpp_q    <= 1'b0;
    end else begin
      case (state_q)
        EIdle: if (start_i) state_q <= EDatRd;
        EDatRd: state_q <= EDatChk;
        EDatChk: begin
          invalid_q <= !dat.rdata.valid;
          acked_q   <= 1'b0;
          bit_q     <= '0;
          div_q     <= '0;
          if (dat.rdata.valid) begin
            // START, SDA falls while SCL is high
            sda_q   <= 1'b0;
            state_q <= EStart;
          end else begin
            state_q <= EDstRd;
          end
        end
        EStart: begin
          div_q <= div_q + 1'b1;
          if (half_done) begin
            scl_q   <= 1'b0;
            state_q <= EBitLo;
          end
        end
        EBitLo: begin
          div_q <= div_q + 1'b1;
          if (div_q == DivMid) begin
            sda_q  <= shift_q[FrameBits-1];
            odpp_q <= bit_q >= DataBit;
          end
          if (half_done) begin
            scl_q   <= 1'b1;
            state_q <= EBitHi;
          end
        end
        EBitHi: begin
          div_q <= div_q + 1'b1;
          if (bit_q == AckBit && div_q == DivMid) begin
            acked_q <= !sda_i;
          end
          if (half_done) begin
            scl_q <= 1'b0;
            bit_q <= bit_q + 1'b1;
            // NACK skips the data phase
            if (bit_q == LastBit || (bit_q == AckBit && !acked_q)) begin
              state_q <= EStopLo;
            end else begin
              state_q <= EBitLo;
            end
          end
        end
        EStopLo: begin
          div_q <= div_q + 1'b1;
          if (div_q == DivMid) begin
            sda_q  <= 1'b0;
            odpp_q <= 1'b0;
          end
          if (half_done) begin
            scl_q   <= 1'b1;
            state_q <= EStopHi;
          end
        end
        EStopHi: begin
          div_q <= div_q + 1'b1;
          if (half_done) begin
            // STOP, SDA rises while SCL is high
            sda_q   <= 1'b1;
            state_q <= EDstRd;
          end
        end
        EDstRd: state_q <= EDstWr;
        EDstWr: state_q <= EIdle;
        default: state_q <= EIdle;
      endcase
    end
  end

endmodule

//--- i3c_csr_frontend.sv
// Host must keep all request inputs stable from csr_req_i rise until csr_ack_o rises
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_csr_frontend (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  csr_req_i,
  input  logic                  csr_we_i,
  input  logic [7:0]            csr_addr_i,
  input  logic [15:0]           csr_wdata_i,
  output logic                  csr_ack_o,
  output logic [15:0]           csr_rdata_o,
  input  logic                  eng_busy_i,
  output logic                  eng_start_o,
  output logic [`I3C_IDX_W-1:0] eng_idx_o,
  output logic [7:0]            eng_data_o,
  i3c_table_if.client           dat,
  i3c_table_if.client           dst
);

  typedef enum logic [1:0] {FeIdle, FeWait, FeAck} fe_state_e;
  typedef enum logic [1:0] {SelNone, SelDat, SelDst} rd_sel_e;

  fe_state_e          state_q;
  rd_sel_e            sel_q;
  i3c_pkg::csr_rsp_t  rsp_q;
  logic [7:0]         dat_off;
  logic [7:0]         dst_off;
  logic               is_dat;
  logic               is_dst;
  logic               is_cmd;
  logic               is_status;
  logic               needs_tables;
  logic               accept;

  assign dat_off   = csr_addr_i - `I3C_CSR_DAT_BASE;
  assign dst_off   = csr_addr_i - `I3C_CSR_DST_BASE;
  assign is_dat    = dat_off < 8'(`I3C_TABLE_DEPTH);
  assign is_dst    = dst_off < 8'(`I3C_TABLE_DEPTH);
  assign is_cmd    = csr_addr_i == `I3C_CSR_CMD;
  assign is_status = csr_addr_i == `I3C_CSR_STATUS;

  // Tables and command wait for an idle engine, status never waits
  assign needs_tables = is_dat | is_dst | is_cmd;
  assign accept = (state_q == FeIdle) && csr_req_i && !(needs_tables && eng_busy_i);

  assign dat.req   = accept && is_dat;
  assign dat.write = csr_we_i;
  assign dat.addr  = dat_off[`I3C_IDX_W-1:0];
  assign dat.wdata = i3c_pkg::dat_entry_t'(csr_wdata_i[7:0]);

  // DST is read-only from the host
  assign dst.req   = accept && is_dst && !csr_we_i;
  assign dst.write = 1'b0;
  assign dst.addr  = dst_off[`I3C_IDX_W-1:0];
  assign dst.wdata = '0;

  assign eng_start_o = accept && is_cmd && csr_we_i;
  assign eng_idx_o   = csr_wdata_i[`I3C_IDX_W-1:0];
  assign eng_data_o  = csr_wdata_i[15:8];

  assign csr_ack_o   = rsp_q.ack;
  assign csr_rdata_o = rsp_q.rdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FeIdle;
      sel_q   <= SelNone;
      rsp_q   <= '0;
    end else begin
      case (state_q)
        FeIdle: begin
          if (accept && needs_tables) begin
            state_q <= FeWait;
            if (csr_we_i) begin
              sel_q <= SelNone;
            end else if (is_dat) begin
              sel_q <= SelDat;
            end else if (is_dst) begin
              sel_q <= SelDst;
            end else begin
              sel_q <= SelNone;
            end
          end else if (accept) begin
            // Status and unmapped addresses answer at once
            state_q     <= FeAck;
            rsp_q.ack   <= 1'b1;
            rsp_q.rdata <= (is_status && !csr_we_i) ? {15'd0, eng_busy_i} : 16'd0;
          end
        end
        FeWait: begin
          state_q   <= FeAck;
          rsp_q.ack <= 1'b1;
          case (sel_q)
            SelDat:  rsp_q.rdata <= {8'h00, dat.rdata};
            SelDst:  rsp_q.rdata <= {6'h00, dst.rdata};
            default: rsp_q.rdata <= 16'd0;
          endcase
        end
        FeAck: begin
          if (!csr_req_i) begin
            state_q   <= FeIdle;
            rsp_q.ack <= 1'b0;
          end
        end
        default: state_q <= FeIdle;
      endcase
    end
  end

endmodule

//--- i3c_table_ram.sv
// Single port only; entry_t must match the entry type of the connected interface
`timescale 1ns/100ps
`include "i3c_params.svh"

module i3c_table_ram #(
  parameter type         entry_t = logic [7:0],
  parameter int unsigned Depth   = `I3C_TABLE_DEPTH
) (
  input logic         clk_i,
  input logic         arst_n_i,
  i3c_table_if.memory mem
);

  entry_t entries_q [Depth];

  // Registered read, write at the edge with req high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < Depth; i++) begin
        entries_q[i] <= '0;
      end
      mem.rdata <= '0;
    end else if (mem.req) begin
      if (mem.write) begin
        entries_q[mem.addr] <= mem.wdata;
      end else begin
        mem.rdata <= entries_q[mem.addr];
      end
    end
  end

endmodule

//--- i3c_table_if.sv
// Address width is fixed by I3C_IDX_W and rdata is valid one clock after a read request
`timescale 1ns/100ps
`include "i3c_params.svh"

interface i3c_table_if #(
  parameter type entry_t = logic [7:0]
);

  logic                  req;
  logic                  write;
  logic [`I3C_IDX_W-1:0] addr;
  entry_t                wdata;
  entry_t                rdata;

  // Requester side, core or engine
  modport client (output req, output write, output addr, output wdata, input rdata);

  // Storage side
  modport memory (input req, input write, input addr, input wdata, output rdata);

endinterface

//--- i3c_pkg.sv
// Entry layouts here are also the CSR bit views, so reordering fields changes the register map
package i3c_pkg;

  // Device address table entry
  // Bit 7 valid, bits 6..0 dynamic address
  typedef struct packed {
    logic       valid;
    logic [6:0] addr;
  } dat_entry_t;

  // Device status table entry
  // Bit 9 invalid, bit 8 nack, bits 7..0 acknowledged transfers
  typedef struct packed {
    logic       invalid;
    logic       nack;
    logic [7:0] count;
  } dst_entry_t;

  // Registered response of the register port
  typedef struct packed {
    logic        ack;
    logic [15:0] rdata;
  } csr_rsp_t;

endpackage

//--- i3c_params.svh
// Table depth must equal 2**I3C_IDX_W and I3C_SCL_DIV must be a power of two of at least 2
`ifndef I3C_PARAMS_SVH
`define I3C_PARAMS_SVH

// Entries per device table
`define I3C_TABLE_DEPTH 8
`define I3C_IDX_W 3

// System clocks per SCL half period
`define I3C_SCL_DIV 4

// Register port word addresses
`define I3C_CSR_DAT_BASE 8'h00
`define I3C_CSR_DST_BASE 8'h10
`define I3C_CSR_CMD 8'h20
`define I3C_CSR_STATUS 8'h21

`endif
